//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_jackal_input
FLIST     ?= flist.f
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

//--- flist.f
+incdir+hw
hw/jackal_input_pkg.sv
hw/rom_load_bridge.sv
hw/ps2_key_decoder.sv
hw/rotary_dial.sv
hw/control_mapper.sv
hw/board_config.sv
hw/jackal_input_top.sv
verif/jackal_input_chk.sv
verif/tb_jackal_input.sv

//--- hw/board_config.sv
// ROM header flag capture and DIP switch bytes from host writes
`timescale 1ns/1ps
`default_nettype none

`include "jackal_input_defines.svh"

module board_config (
	input  logic                         CLK_49M,
	input  logic                         arst_n,
	input  jackal_input_pkg::host_wr_t   host,
	output jackal_input_pkg::board_cfg_t cfg
);
	import jackal_input_pkg::*;

	localparam int DIP_USED = 3;  // Banks wired to the game core

	cfg_byte_u  wr_byte;
	logic       hdr_hit, dip_hit;
	logic [1:0] bootleg_q;
	logic       rotary_q;
	logic [7:0] dip_q [DIP_USED];  // Raw, active high as sent

	assign wr_byte.raw = host.data;

	assign hdr_hit = host.wr && (host.index == `IDX_ROM) && (host.addr == '0);
	assign dip_hit = host.wr && (host.index == `IDX_DIP) && (host.addr < `DIP_BYTES);

	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			bootleg_q <= 2'b00;
			rotary_q  <= 1'b0;
			for (int i = 0; i < DIP_USED; i++) dip_q[i] <= 8'h00;
		end else begin
			if (hdr_hit) begin
				bootleg_q <= wr_byte.hdr.bootleg;
				rotary_q  <= wr_byte.hdr.rotary;
			end
			// Banks 3..7 accepted from the host but not wired anywhere
			if (dip_hit && (host.addr[2:0] < DIP_USED))
				dip_q[host.addr[1:0]] <= wr_byte.raw;
		end
	end

	assign cfg.bootleg       = bootleg_q;
	assign cfg.rotary_fitted = rotary_q;
	assign cfg.dipsw         = ~{dip_q[2], dip_q[1], dip_q[0]};  // Bank 2 on top

endmodule

`default_nettype wire

//--- hw/control_mapper.sv
// Key and pad merge, shared dial step divider and active-low cabinet word
`timescale 1ns/1ps
`default_nettype none

`include "jackal_input_defines.svh"

module control_mapper #(
	parameter int ROT_DIV_W = `ROT_DIV_W
) (
	input  logic                          CLK_49M,
	input  logic                          arst_n,
	input  jackal_input_pkg::key_state_t  keys,
	input  logic [15:0]                   pad0,      // Player 1 gamepad
	input  logic [15:0]                   pad1,      // Player 2 gamepad
	input  logic                          fast_dial, // Double dial rate
	input  jackal_input_pkg::board_cfg_t  cfg,
	output jackal_input_pkg::cabinet_in_t cabinet
);
	import jackal_input_pkg::*;

	logic [ROT_DIV_W-1:0] rot_div;
	logic                 step_en;
	logic [7:0]           rot1, rot2;
	logic [7:0]           rot1_eff, rot2_eff;
	logic                 dials_off;
	player_keys_t         p1, p2;

	// Pad bits right 0, left 1, down 2, up 3, shot 4, missile 5
	function automatic player_keys_t merge_pad(input player_keys_t k, input logic [15:0] pad);
		player_keys_t m;
		m.right   = k.right   | pad[0];
		m.left    = k.left    | pad[1];
		m.down    = k.down    | pad[2];
		m.up      = k.up      | pad[3];
		m.shot    = k.shot    | pad[4];
		m.missile = k.missile | pad[5];
		return m;
	endfunction

	assign p1 = merge_pad(keys.p1, pad0);
	assign p2 = merge_pad(keys.p2, pad1);

	// ==========================================================
	// Dials
	// ==========================================================
	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) rot_div <= '0;
		else         rot_div <= rot_div + 1'b1;
	end

	// Fast mode ignores the top divider bit
	assign step_en = fast_dial ? (rot_div[ROT_DIV_W-2:0] == '0) : (rot_div == '0);

	rotary_dial u_dial_p1 (
		.CLK_49M(CLK_49M), .arst_n(arst_n), .step_en(step_en),
		.turn_left(pad0[7]), .turn_right(pad0[6]), .position(rot1)
	);
	rotary_dial u_dial_p2 (
		.CLK_49M(CLK_49M), .arst_n(arst_n), .step_en(step_en),
		.turn_left(pad1[7]), .turn_right(pad1[6]), .position(rot2)
	);

	// Bootleg PCB has no dial hardware
	assign dials_off = (cfg.bootleg == 2'b01);
	assign rot1_eff  = dials_off ? 8'hFF : rot1;
	assign rot2_eff  = dials_off ? 8'hFF : rot2;

	// Cabinet word, everything inverted
	assign cabinet.coins   = ~{keys.coin2, keys.coin1 | pad0[9] | pad1[9]};
	assign cabinet.service = ~keys.service;
	assign cabinet.start   = ~{keys.start2 | pad1[8], keys.start1 | pad0[8]};
	assign cabinet.p1_joy  = ~{p1.down, p1.up, p1.right, p1.left};
	assign cabinet.p2_joy  = ~{p2.down, p2.up, p2.right, p2.left};
	assign cabinet.p1_btn  = ~{p1.missile, p1.shot};
	assign cabinet.p2_btn  = ~{p2.missile, p2.shot};
	assign cabinet.p1_rot  = ~rot1_eff;
	assign cabinet.p2_rot  = ~rot2_eff;

endmodule

`default_nettype wire

//--- hw/jackal_input_defines.svh
// Download windows, offsets, bus widths, dial divider, download indices and PS/2 key codes
`ifndef JACKAL_INPUT_DEFINES_SVH
`define JACKAL_INPUT_DEFINES_SVH

// ==========================================================
// ROM download windows
// ==========================================================
`define ROM_WIN_A     25'h20000  // Hi lane
`define ROM_WIN_B     25'h40000  // Lo lane
`define ROM_WIN_C     25'h60000  // Hi lane
`define ROM_WIN_D     25'h80000  // Lo lane
`define ROM_WIN_SIZE  25'h10000

// Subtracted from host address to get the SDRAM word address
`define ROM_OFS_A     24'h20000
`define ROM_OFS_B     24'h40000
`define ROM_OFS_C     24'h50000
`define ROM_OFS_D     24'h70000

`define HOST_ADDR_W   25
`define SDRAM_ADDR_W  24

// Dial step divider, full rate is one step per 2^ROT_DIV_W clocks
`define ROT_DIV_W     23

// Host download slots
`define IDX_ROM       8'd1
`define IDX_DIP       8'd254
`define DIP_BYTES     8

// ==========================================================
// PS/2 set 2 make codes
// ==========================================================
`define KEY_START1    8'h16  // 1
`define KEY_START2    8'h1E  // 2
`define KEY_COIN1     8'h2E  // 5
`define KEY_COIN2     8'h36  // 6
`define KEY_SERVICE   8'h46  // 9
`define KEY_PAUSE     8'h4D  // P
`define KEY_P1_UP     8'h75  // Cursor keys, E0 prefixed
`define KEY_P1_DOWN   8'h72
`define KEY_P1_LEFT   8'h6B
`define KEY_P1_RIGHT  8'h74
`define KEY_P1_SHOT   8'h14  // Ctrl
`define KEY_P1_MISS   8'h11  // Alt
`define KEY_P2_UP     8'h1D  // W
`define KEY_P2_DOWN   8'h1B  // S
`define KEY_P2_LEFT   8'h1C  // A
`define KEY_P2_RIGHT  8'h23  // D
`define KEY_P2_SHOT   8'h2A  // V
`define KEY_P2_MISS   8'h32  // B

`endif

//--- hw/jackal_input_pkg.sv
// Host and SDRAM write events, key and cabinet words, header byte union and board config
`default_nettype none

`include "jackal_input_defines.svh"

package jackal_input_pkg;

	// ==========================================================
	// Download side
	// ==========================================================

	// One byte from the host loader
	typedef struct packed {
		logic                    wr;     // Byte strobe
		logic [7:0]              index;  // Download slot
		logic [`HOST_ADDR_W-1:0] addr;
		logic [7:0]              data;
	} host_wr_t;

	// One SDRAM word write, byte placed on both halves
	typedef struct packed {
		logic [`SDRAM_ADDR_W-1:0] addr;
		logic [15:0]              data;
		logic                     lane_lo;  // Write enable, low byte
		logic                     lane_hi;  // Write enable, high byte
	} sdram_wr_t;

	// ==========================================================
	// Controls
	// ==========================================================

	// Held buttons of one player, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic shot;
		logic missile;
	} player_keys_t;

	typedef struct packed {
		player_keys_t p1;
		player_keys_t p2;
		logic         start1;
		logic         start2;
		logic         coin1;
		logic         coin2;
		logic         service;
	} key_state_t;

	// Cabinet inputs, all active low
	typedef struct packed {
		logic [1:0] coins;   // {coin2, coin1}
		logic       service;
		logic [1:0] start;   // {start2, start1}
		logic [3:0] p1_joy;  // {down, up, right, left}
		logic [3:0] p2_joy;
		logic [1:0] p1_btn;  // {missile, shot}
		logic [1:0] p2_btn;
		logic [7:0] p1_rot;  // One-cold dial
		logic [7:0] p2_rot;
	} cabinet_in_t;

	// ==========================================================
	// Board configuration
	// ==========================================================

	// First byte of the ROM image
	typedef struct packed {
		logic [2:0] rsvd_hi;
		logic       rotary;   // Rotary dials fitted
		logic [1:0] rsvd_lo;
		logic [1:0] bootleg;  // 01 = bootleg board without dials
	} rom_header_t;

	// Same host byte, raw for DIP slots or split as header flags
	typedef union packed {
		logic [7:0]  raw;
		rom_header_t hdr;
	} cfg_byte_u;

	typedef struct packed {
		logic [1:0]  bootleg;
		logic        rotary_fitted;
		logic [23:0] dipsw;  // Active low, bank 2 on top
	} board_cfg_t;

endpackage

`default_nettype wire

//--- hw/jackal_input_top.sv
// Input and loader top level with ROM bridge, key decoder, control mapper and board config
`timescale 1ns/1ps
`default_nettype none

`include "jackal_input_defines.svh"

module jackal_input_top #(
	parameter int ROT_DIV_W = `ROT_DIV_W
) (
	input  logic                          CLK_49M,
	input  logic                          arst_n,
	// Host loader
	input  logic                          download,
	input  jackal_input_pkg::host_wr_t    host,
	output logic                          host_wait,
	// SDRAM write port
	output jackal_input_pkg::sdram_wr_t   sdram_wr,
	output logic                          sdram_req,
	input  logic                          sdram_ack,
	// Controls
	input  logic [10:0]                   ps2_key,
	input  logic [15:0]                   pad0,
	input  logic [15:0]                   pad1,
	input  logic                          fast_dial,
	// To game core
	output jackal_input_pkg::cabinet_in_t cabinet,
	output jackal_input_pkg::board_cfg_t  cfg
);
	import jackal_input_pkg::*;

	key_state_t keys;  // Decoder to mapper

	// ==========================================================
	// Loader side
	// ==========================================================
	rom_load_bridge u_rom_load_bridge (
		.CLK_49M  (CLK_49M),
		.arst_n   (arst_n),
		.download (download),
		.host     (host),
		.host_wait(host_wait),
		.sdram_wr (sdram_wr),
		.sdram_req(sdram_req),
		.sdram_ack(sdram_ack)
	);

	board_config u_board_config (
		.CLK_49M(CLK_49M),
		.arst_n (arst_n),
		.host   (host),
		.cfg    (cfg)       // Also feeds the bootleg dial override
	);

	// ==========================================================
	// Control side
	// ==========================================================
	ps2_key_decoder u_ps2_key_decoder (
		.CLK_49M(CLK_49M),
		.arst_n (arst_n),
		.ps2_key(ps2_key),
		.keys   (keys)
	);

	control_mapper #(
		.ROT_DIV_W(ROT_DIV_W)
	) u_control_mapper (
		.CLK_49M  (CLK_49M),
		.arst_n   (arst_n),
		.keys     (keys),
		.pad0     (pad0),
		.pad1     (pad1),
		.fast_dial(fast_dial),
		.cfg      (cfg),
		.cabinet  (cabinet)
	);

endmodule

`default_nettype wire

//--- hw/ps2_key_decoder.sv
// PS/2 event strobe detection and key code to held button state register
`timescale 1ns/1ps
`default_nettype none

`include "jackal_input_defines.svh"

module ps2_key_decoder (
	input  logic                         CLK_49M,
	input  logic                         arst_n,
	input  logic [10:0]                  ps2_key,  // {strobe, pressed, ext, code}
	output jackal_input_pkg::key_state_t keys
);
	logic [9:0] ps2_q;        // Sampled {strobe, pressed, code}
	logic       strobe_prev;
	logic       key_event;
	logic       pressed;
	logic [7:0] code;

	// Extended flag dropped, cursor codes don't clash with the rest
	assign pressed   = ps2_q[8];
	assign code      = ps2_q[7:0];
	assign key_event = ps2_q[9] ^ strobe_prev;  // Strobe flips once per event

	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			ps2_q       <= '0;
			strobe_prev <= 1'b0;
			keys        <= '0;   // All released
		end else begin
			ps2_q       <= {ps2_key[10:9], ps2_key[7:0]};
			strobe_prev <= ps2_q[9];
			if (key_event) begin
				case (code)
					`KEY_START1:   keys.start1     <= pressed;
					`KEY_START2:   keys.start2     <= pressed;
					`KEY_COIN1:    keys.coin1      <= pressed;
					`KEY_COIN2:    keys.coin2      <= pressed;
					`KEY_SERVICE:  keys.service    <= pressed;
					`KEY_PAUSE:    ;                // Known key, no pause logic here
					// Player 1
					`KEY_P1_UP:    keys.p1.up      <= pressed;
					`KEY_P1_DOWN:  keys.p1.down    <= pressed;
					`KEY_P1_LEFT:  keys.p1.left    <= pressed;
					`KEY_P1_RIGHT: keys.p1.right   <= pressed;
					`KEY_P1_SHOT:  keys.p1.shot    <= pressed;
					`KEY_P1_MISS:  keys.p1.missile <= pressed;
					// Player 2
					`KEY_P2_UP:    keys.p2.up      <= pressed;
					`KEY_P2_DOWN:  keys.p2.down    <= pressed;
					`KEY_P2_LEFT:  keys.p2.left    <= pressed;
					`KEY_P2_RIGHT: keys.p2.right   <= pressed;
					`KEY_P2_SHOT:  keys.p2.shot    <= pressed;
					`KEY_P2_MISS:  keys.p2.missile <= pressed;
					default:       ;                // Unmapped code
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/rom_load_bridge.sv
// Window decode, address offset, lane select and SDRAM toggle handshake for ROM download
`timescale 1ns/1ps
`default_nettype none

`include "jackal_input_defines.svh"

module rom_load_bridge (
	input  logic                        CLK_49M,
	input  logic                        arst_n,
	input  logic                        download,   // Loader active
	input  jackal_input_pkg::host_wr_t  host,
	output logic                        host_wait,  // Hold off next host byte
	output jackal_input_pkg::sdram_wr_t sdram_wr,
	output logic                        sdram_req,  // Toggles per write
	input  logic                        sdram_ack   // Follows req when done
);
	localparam logic [`HOST_ADDR_W-1:0]  WIN_SIZE = `ROM_WIN_SIZE;
	localparam logic [`SDRAM_ADDR_W-1:0] OFS_A    = `ROM_OFS_A;
	localparam logic [`SDRAM_ADDR_W-1:0] OFS_B    = `ROM_OFS_B;
	localparam logic [`SDRAM_ADDR_W-1:0] OFS_C    = `ROM_OFS_C;
	localparam logic [`SDRAM_ADDR_W-1:0] OFS_D    = `ROM_OFS_D;

	logic                     hit_a, hit_b, hit_c, hit_d;
	logic                     accept;
	logic [`SDRAM_ADDR_W-1:0] win_ofs;

	function automatic logic in_window(input logic [`HOST_ADDR_W-1:0] a,
	                                   input logic [`HOST_ADDR_W-1:0] base);
		return (a >= base) && (a < base + WIN_SIZE);
	endfunction

	// ==========================================================
	// Window decode
	// ==========================================================
	assign hit_a = in_window(host.addr, `ROM_WIN_A);
	assign hit_b = in_window(host.addr, `ROM_WIN_B);
	assign hit_c = in_window(host.addr, `ROM_WIN_C);
	assign hit_d = in_window(host.addr, `ROM_WIN_D);

	assign accept = host.wr & download & (hit_a | hit_b | hit_c | hit_d);

	always_comb begin
		win_ofs = OFS_A;           // Don't care outside windows
		if (hit_b) win_ofs = OFS_B;
		if (hit_c) win_ofs = OFS_C;
		if (hit_d) win_ofs = OFS_D;
	end

	// Payload held until ack catches up
	always_ff @(posedge CLK_49M) begin
		if (accept) begin
			sdram_wr.addr    <= host.addr[`SDRAM_ADDR_W-1:0] - win_ofs;
			sdram_wr.data    <= {host.data, host.data};
			sdram_wr.lane_hi <= hit_a | hit_c;
			sdram_wr.lane_lo <= hit_b | hit_d;
		end
	end

	// Toggle handshake, one write in flight
	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			sdram_req <= 1'b0;
			host_wait <= 1'b0;
		end else if (accept) begin
			sdram_req <= ~sdram_req;
			host_wait <= 1'b1;
		end else if (host_wait && (sdram_req == sdram_ack)) begin
			host_wait <= 1'b0;  // Memory has taken the word
		end
	end

endmodule

`default_nettype wire

//--- hw/rotary_dial.sv
// One-hot eight position rotary dial with wraparound stepping
`timescale 1ns/1ps
`default_nettype none

module rotary_dial (
	input  logic       CLK_49M,
	input  logic       arst_n,
	input  logic       step_en,     // Shared divider tick
	input  logic       turn_left,
	input  logic       turn_right,
	output logic [7:0] position     // One-hot, active high
);

	// Left walks the bit up, right walks it down
	// Rotate gives the 80->01 and 01->80 wrap for free
	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			position <= 8'h01;
		end else if (step_en) begin
			if (turn_left) begin
				position <= {position[6:0], position[7]};
			end else if (turn_right) begin
				position <= {position[0], position[7:1]};
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/jackal_input_chk.sv
// Concurrent assertions for the ROM write handshake and the dial one-hot encoding, with binds
`timescale 1ns/1ps
`default_nettype none

module jackal_input_chk #(
	parameter bit BRIDGE = 1'b1  // 1 = handshake checks, 0 = dial checks
) (
	input logic       CLK_49M,
	input logic       arst_n,
	input logic       req,
	input logic       ack,
	input logic       hold,      // host_wait
	input logic [7:0] position
);

	// ==========================================================
	// Handshake or dial
	// ==========================================================
	if (BRIDGE) begin : g_bridge
		// New request only when the previous one is done
		a_req_idle: assert property (@(posedge CLK_49M) disable iff (!arst_n)
			(req != $past(req)) |-> !$past(hold))
			else $error("sdram_req toggled while host_wait was high");
		a_wait_ack: assert property (@(posedge CLK_49M) disable iff (!arst_n)
			($past(hold) && !hold) |-> $past(req == ack))
			else $error("host_wait cleared before acknowledge");
	end else begin : g_dial
		a_onehot: assert property (@(posedge CLK_49M) disable iff (!arst_n)
			$onehot(position))
			else $error("dial position not one-hot");
	end

endmodule

bind rom_load_bridge jackal_input_chk #(.BRIDGE(1'b1)) u_chk (
	.CLK_49M(CLK_49M), .arst_n(arst_n), .req(sdram_req), .ack(sdram_ack),
	.hold(host_wait), .position(8'h01)
);

bind rotary_dial jackal_input_chk #(.BRIDGE(1'b0)) u_chk (
	.CLK_49M(CLK_49M), .arst_n(arst_n), .req(1'b0), .ack(1'b0),
	.hold(1'b0), .position(position)
);

`default_nettype wire

//--- verif/tb_jackal_input.sv
// Table-driven testbench with SDRAM ack model, LFSR delays, compare tasks and timeout
`timescale 1ns/1ps
`default_nettype none

`include "jackal_input_defines.svh"

module tb_jackal_input;
	import jackal_input_pkg::*;

	localparam int OP_HOST = 0, OP_KEY = 1, OP_PAD = 2, OP_DIAL = 3, OP_CFG = 4;

	// One table row, mask holds cleared cabinet bits or dial fields in 15:0
	typedef struct {
		int          kind;
		int          a, b, c, d;
		logic [32:0] mask;
		sdram_wr_t   wr;
		board_cfg_t  cfg;
	} entry_t;

	logic CLK_49M = 1'b0;
	logic arst_n, download, host_wait, sdram_req, sdram_ack, fast_dial;
	logic [10:0] ps2_key;
	logic [15:0] pad0, pad1;
	host_wr_t    host;
	sdram_wr_t   sdram_wr;
	cabinet_in_t cabinet;
	board_cfg_t  cfg;

	entry_t      tbl[$];
	logic [15:0] lfsr = 16'd21382;
	logic [32:0] key_held = '0;        // Model of held keys
	logic [32:0] pad_mask = '0;        // Model of pad buttons
	logic [7:0]  rot1_n = 8'hFE;
	logic [7:0]  rot2_n = 8'hFE;
	logic [1:0]  boot = 2'b00;
	int          cycles = 0;
	int          cyc = 0;              // Edges since reset release
	int          limit = 0;

	// Codes and their cabinet bit positions
	logic [7:0] key_code [17] = '{`KEY_START1, `KEY_START2, `KEY_COIN1, `KEY_COIN2,
		`KEY_SERVICE, `KEY_P1_UP, `KEY_P1_DOWN, `KEY_P1_LEFT, `KEY_P1_RIGHT, `KEY_P1_SHOT,
		`KEY_P1_MISS, `KEY_P2_UP, `KEY_P2_DOWN, `KEY_P2_LEFT, `KEY_P2_RIGHT, `KEY_P2_SHOT,
		`KEY_P2_MISS};
	int key_bit [17] = '{28, 29, 31, 32, 30, 26, 27, 24, 25, 18, 19, 22, 23, 20, 21, 16, 17};

	jackal_input_top #(.ROT_DIV_W(6)) dut_i (
		.CLK_49M(CLK_49M), .arst_n(arst_n), .download(download), .host(host),
		.host_wait(host_wait), .sdram_wr(sdram_wr), .sdram_req(sdram_req),
		.sdram_ack(sdram_ack), .ps2_key(ps2_key), .pad0(pad0), .pad1(pad1),
		.fast_dial(fast_dial), .cabinet(cabinet), .cfg(cfg)
	);

	initial begin
		forever #4 CLK_49M = ~CLK_49M;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic entry_t mk(int kind, int a, int b, int c, int d,
	                              logic [32:0] mask = '0, sdram_wr_t wr = '0,
	                              board_cfg_t cfg_exp = '0);
		entry_t e;
		e.kind = kind;
		e.a    = a;
		e.b    = b;
		e.c    = c;
		e.d    = d;
		e.mask = mask;
		e.wr   = wr;
		e.cfg  = cfg_exp;
		return e;
	endfunction

	// ==========================================================
	// Compare tasks
	// ==========================================================
	task automatic fail_now(string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_wr(string name, sdram_wr_t got, sdram_wr_t exp);
		if (got !== exp) fail_now($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_cab(string name, cabinet_in_t got, cabinet_in_t exp);
		if (got !== exp) fail_now($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_cfg(string name, board_cfg_t got, board_cfg_t exp);
		if (got !== exp) fail_now($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) fail_now($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
	endtask

	// Idle word with model buttons cleared, bootleg 01 kills the dials
	task automatic check_cabinet();
		logic [32:0] v;
		v = {17'h1FFFF, rot1_n, rot2_n};
		if (boot == 2'b01) v[15:0] = 16'h0000;
		v = v & ~(key_held | pad_mask);
		check_cab("cabinet", cabinet, cabinet_in_t'(v));
	endtask

	// SDRAM ack model, 0..7 cycle delay per write
	initial begin
		logic       busy;
		logic [2:0] dly;
		sdram_ack = 1'b0;
		busy      = 1'b0;
		dly       = '0;
		forever begin
			@(negedge CLK_49M);
			if (arst_n && (sdram_req != sdram_ack)) begin
				if (!busy) begin
					busy = 1'b1;
					dly  = {lfsr_bit(), lfsr_bit(), lfsr_bit()};
				end
				if (dly == 3'd0) begin
					sdram_ack = sdram_req;
					busy      = 1'b0;
				end else dly = dly - 1'b1;
			end
		end
	end

	always @(posedge CLK_49M) begin
		cycles++;
		if (arst_n) cyc++;
		if (limit > 0 && cycles > limit) fail_now("Timeout, the run took too many cycles");
	end

	// ==========================================================
	// Main sequence
	// ==========================================================
	initial begin
		logic req_exp;  // Model of the request toggle
		int   per;
		arst_n    = 1'b0;
		download  = 1'b0;
		host      = '0;
		ps2_key   = '0;
		pad0      = '0;
		pad1      = '0;
		fast_dial = 1'b0;
		req_exp   = 1'b0;

		// Windows A..D, then outside a window and download low
		tbl.push_back(mk(OP_HOST, 1, 'h20010, 'h5A, 1, '0, {24'h000010, 16'h5A5A, 1'b0, 1'b1}));
		tbl.push_back(mk(OP_HOST, 1, 'h4FFFF, 'hA5, 1, '0, {24'h00FFFF, 16'hA5A5, 1'b1, 1'b0}));
		tbl.push_back(mk(OP_HOST, 1, 'h60000, 'h3C, 1, '0, {24'h010000, 16'h3C3C, 1'b0, 1'b1}));
		tbl.push_back(mk(OP_HOST, 1, 'h8ABCD, 'hC3, 1, '0, {24'h01ABCD, 16'hC3C3, 1'b1, 1'b0}));
		tbl.push_back(mk(OP_HOST, 1, 'h30000, 'h11, 0));
		tbl.push_back(mk(OP_HOST, 1, 'h90000, 'h22, 0));
		tbl.push_back(mk(OP_HOST, 0, 'h20020, 'h33, 0));
		for (int i = 0; i < 17; i++) tbl.push_back(mk(OP_KEY, int'(key_code[i]), 1, key_bit[i], 0));
		for (int i = 0; i < 17; i++) tbl.push_back(mk(OP_KEY, int'(key_code[i]), 0, key_bit[i], 0));
		tbl.push_back(mk(OP_KEY, int'(`KEY_PAUSE), 1, -1, 0));
		tbl.push_back(mk(OP_KEY, 'h55, 1, -1, 0));
		// Pads alone, then key and pad on the same button
		tbl.push_back(mk(OP_PAD, 'h033F, 0, 0, 0, 33'h09F0C0000));
		tbl.push_back(mk(OP_PAD, 0, 'h023F, 0, 0, 33'h080F30000));
		tbl.push_back(mk(OP_PAD, 0, 'h0100, 0, 0, 33'h020000000));
		tbl.push_back(mk(OP_PAD, 0, 0, 0, 0));
		tbl.push_back(mk(OP_KEY, int'(`KEY_P1_SHOT), 1, 18, 0));
		tbl.push_back(mk(OP_PAD, 'h0010, 0, 0, 0, 33'h000040000));
		tbl.push_back(mk(OP_KEY, int'(`KEY_P1_SHOT), 0, 18, 0));
		tbl.push_back(mk(OP_PAD, 0, 0, 0, 0));
		// P1 left 9 slow, P2 right 9 slow, then P1 right 2 fast
		tbl.push_back(mk(OP_DIAL, 'h80, 'h40, 0, 9, 33'h0FD7F));
		tbl.push_back(mk(OP_DIAL, 'h40, 0, 1, 2, 33'h07F7F));
		tbl.push_back(mk(OP_CFG, 1, 0, 'h12, 0, '0, '0, {2'b10, 1'b1, 24'hFFFFFF}));
		tbl.push_back(mk(OP_CFG, 254, 0, 'h11, 0, '0, '0, {2'b10, 1'b1, 24'hFFFFEE}));
		tbl.push_back(mk(OP_CFG, 254, 1, 'h22, 0, '0, '0, {2'b10, 1'b1, 24'hFFDDEE}));
		tbl.push_back(mk(OP_CFG, 254, 2, 'h33, 0, '0, '0, {2'b10, 1'b1, 24'hCCDDEE}));
		tbl.push_back(mk(OP_CFG, 254, 3, 'hFF, 0, '0, '0, {2'b10, 1'b1, 24'hCCDDEE}));
		tbl.push_back(mk(OP_CFG, 254, 7, 'h00, 0, '0, '0, {2'b10, 1'b1, 24'hCCDDEE}));
		tbl.push_back(mk(OP_CFG, 1, 0, 'h01, 0, '0, '0, {2'b01, 1'b0, 24'hCCDDEE}));
		limit = tbl.size() * 300;

		repeat (16) @(negedge CLK_49M);
		arst_n = 1'b1;
		@(negedge CLK_49M);
		check_cabinet();
		check_cfg("cfg", cfg, {2'b00, 1'b0, 24'hFFFFFF});
		check_bit("host_wait", host_wait, 1'b0);
		check_bit("sdram_req", sdram_req, 1'b0);

		foreach (tbl[i]) begin
			case (tbl[i].kind)
				OP_HOST: begin
					download = tbl[i].a[0];
					host = {1'b1, `IDX_ROM, tbl[i].b[24:0], tbl[i].c[7:0]};
					@(negedge CLK_49M);
					host.wr = 1'b0;
					req_exp = req_exp ^ tbl[i].d[0];  // One toggle per accepted write
					check_bit("host_wait", host_wait, tbl[i].d[0]);
					check_bit("sdram_req", sdram_req, req_exp);
					while (host_wait) begin
						check_wr("sdram_wr", sdram_wr, tbl[i].wr);  // Held until ack
						@(negedge CLK_49M);
					end
					download = 1'b0;
				end
				OP_KEY: begin
					ps2_key = {~ps2_key[10], tbl[i].b[0], 1'b0, tbl[i].a[7:0]};
					if (tbl[i].c >= 0) key_held[tbl[i].c] = tbl[i].b[0];
					repeat (2) @(negedge CLK_49M);
					check_cabinet();
				end
				OP_PAD: begin
					pad0     = tbl[i].a[15:0];
					pad1     = tbl[i].b[15:0];
					pad_mask = tbl[i].mask;
					@(negedge CLK_49M);
					check_cabinet();
				end
				OP_DIAL: begin
					fast_dial = tbl[i].c[0];
					per = tbl[i].c[0] ? 32 : 64;
					while ((cyc % per) != per / 2) @(negedge CLK_49M);  // Mid-period
					pad0 = tbl[i].a[15:0];
					pad1 = tbl[i].b[15:0];
					repeat (tbl[i].d * per) @(negedge CLK_49M);
					pad0   = '0;
					pad1   = '0;
					rot1_n = tbl[i].mask[15:8];
					rot2_n = tbl[i].mask[7:0];
					check_cabinet();
				end
				default: begin
					host = {1'b1, tbl[i].a[7:0], tbl[i].b[24:0], tbl[i].c[7:0]};
					@(negedge CLK_49M);
					host.wr = 1'b0;
					boot    = tbl[i].cfg.bootleg;
					check_cfg("cfg", cfg, tbl[i].cfg);
					check_cabinet();
				end
			endcase
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
